/* term_text_top.f */
hw/term_pkg.sv
hw/cmd_decode.sv
hw/line_rewrite.sv
hw/text_sequencer.sv
hw/text_ram.sv
hw/term_text_top.sv
sim/term_text_asserts.sv
sim/term_text_tb.sv

/* Makefile */
SIM      = verilator
TOP      = term_text_tb
FILELIST = term_text_top.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ns
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim/term_text_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module term_text_tb;
	import term_pkg::*;

	localparam int n_puts = 24;
	localparam int n_shifts = 6;
	localparam int n_scrolls = 8;
	localparam int n_tail = 5;   // commands queued behind the long scroll
	localparam int n_cmds = (n_puts + 4) + 6 * (cols + 1) + n_shifts * (cols + 1)
		+ n_scrolls * (rows + 1) + 4 * (2 * rows + cols + 1) + (rows + 1 + n_tail);

	logic      clk;
	logic      rst;
	logic      cmd_valid;
	logic      cmd_ready;
	term_cmd_t cmd;
	row_t      disp_addr;
	line_t     disp_line;
	logic      idle;

	line_t     model [rows];  // reference screen
	int        stalls;
	string     test_name;

	term_text_top dut_i (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd       (cmd),
		.disp_addr (disp_addr),
		.disp_line (disp_line),
		.idle      (idle)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopping at the first error");
	endtask

	initial
	begin
		repeat (200 * n_cmds + 1000) @(posedge clk);
		fail_run("timeout: the design never returned to idle");
	end

	// screen update straight from the command rules
	function automatic void apply_model(input term_cmd_t c);
		int    row;
		int    col;
		int    cnt;
		int    mode;
		int    step;
		line_t old;
		line_t blank_row;
		cell_t blank;

		row = int'(c.row);
		col = int'(c.col);
		mode = int'(c.count);
		cnt = (mode == 0) ? 1 : mode;
		blank = '{attr: blank_attr, ch: 8'h20};
		for (int k = 0; k < cols; k++)
			blank_row[k] = blank;
		old = model[row];
		step = (cnt > rows - row) ? rows - row : cnt;
		case (c.op)
			put_char:
				if (int'(c.ch) == 0)
					model[row][col] = '{attr: c.attr, ch: 8'h20};
				else if (int'(c.ch) >= 32)
					model[row][col] = '{attr: c.attr, ch: c.ch};
			erase_line:
				for (int k = 0; k < cols; k++)
					if (mode >= 2 || (mode == 0 && k >= col) || (mode == 1 && k <= col))
						model[row][k] = blank;
			erase_chars:
				for (int k = col; k < cols && k < col + cnt; k++)
					model[row][k] = blank;
			insert_chars:
				for (int k = col; k < cols; k++)
					model[row][k] = (k - cnt >= col) ? old[k - cnt] : blank;
			delete_chars:
				for (int k = col; k < cols; k++)
					model[row][k] = (k + cnt < cols) ? old[k + cnt] : blank;
			insert_lines:
				for (int r = rows - 1; r >= row; r--)
					model[r] = (r - step >= row) ? model[r - step] : blank_row;
			delete_lines:
				for (int r = row; r < rows; r++)
					model[r] = (r + step < rows) ? model[r + step] : blank_row;
			erase_display:
				for (int r = 0; r < rows; r++)
					for (int k = 0; k < cols; k++)
						if (mode >= 2 || (mode == 0 && r * cols + k >= row * cols + col)
							|| (mode == 1 && r * cols + k <= row * cols + col))
							model[r][k] = blank;
		endcase
	endfunction

	// starts and ends 2 ns after a rising edge
	task automatic send(input cmd_op_t op, input int row, input int col, input int count,
		input int ch, input int attr);
		term_cmd_t c;
		logic      ready_seen;

		c.op = op;
		c.row = row_t'(row);
		c.col = col_t'(col);
		c.count = 8'(count);
		c.ch = 8'(ch);
		c.attr = 8'(attr);
		cmd = c;
		cmd_valid = 1'b1;
		do
		begin
			ready_seen = cmd_ready;
			if (!ready_seen)
				stalls++;
			@(posedge clk);
			#2;
		end
		while (!ready_seen);
		cmd_valid = 1'b0;
		apply_model(c);
	endtask

	task automatic wait_idle;
		while (!idle)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic check_screen;
		for (int r = 0; r < rows; r++)
		begin
			disp_addr = row_t'(r);
			@(posedge clk);
			#2;
			assert (disp_line == model[r])
			else
				fail_run($sformatf("MISMATCH %s row %0d expected %h actual %h",
					test_name, r, model[r], disp_line));
		end
	endtask

	task automatic run(input cmd_op_t op, input int row, input int col, input int count,
		input int ch, input int attr);
		send(op, row, col, count, ch, attr);
		wait_idle();
		check_screen();
	endtask

	task automatic fill_row(input int r);
		for (int k = 0; k < cols; k++)
			run(put_char, r, k, 0, 8'h41 + k + r, 8'h10 + r);  // distinct per column
	endtask

	initial
	begin
		int r;
		int n;

		void'($urandom(19));
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		disp_addr = '0;
		stalls = 0;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;

		test_name = "clear_put";
		run(erase_display, 0, 0, 2, 0, 0);
		for (int i = 0; i < n_puts; i++)
			run(put_char, $urandom % rows, $urandom % cols, 0, 8'h21 + $urandom % 94,
				$urandom % 256);
		run(put_char, 3, 5, 0, 0, 8'h4e);  // null shows as a space
		run(put_char, 3, 6, 0, 8'h5a, 8'h1f);
		run(put_char, 3, 6, 0, 8'h07, 8'h4e);

		test_name = "erase_line";
		for (int m = 0; m < 3; m++)
		begin
			r = $urandom % rows;
			fill_row(r);
			run(erase_line, r, $urandom % cols, m, 0, 0);
		end
		test_name = "erase_chars";
		for (int i = 0; i < 3; i++)
		begin
			r = $urandom % rows;
			n = (i == 2) ? 20 : i;  // 20 always runs past the last column
			fill_row(r);
			run(erase_chars, r, $urandom % cols, n, 0, 0);
		end

		test_name = "shift_chars";
		r = $urandom % rows;
		for (int i = 0; i < n_shifts; i++)
		begin
			n = (i < 2) ? cols + 3 * i : $urandom % 20;
			fill_row(r);
			if (i % 2 == 1)
				run(delete_chars, r, $urandom % cols, n, 0, 0);
			else
				run(insert_chars, r, $urandom % cols, n, 0, 0);
		end

		test_name = "scroll_lines";
		for (int i = 0; i < n_scrolls; i++)
		begin
			for (int k = 0; k < rows; k++)
				run(put_char, k, 0, 0, 8'h61 + k, 8'h20 + k);  // rows differ in column 0
			if (i % 2 == 1)
				run(delete_lines, $urandom % rows, 0, $urandom % 10, 0, 0);
			else
				run(insert_lines, $urandom % rows, 0, $urandom % 10, 0, 0);
		end

		test_name = "erase_display";
		for (int m = 0; m < 4; m++)
		begin
			r = (m == 2) ? rows - 1 : (m == 3) ? 0 : $urandom % rows;
			for (int i = 0; i < rows; i++)
			begin
				run(put_char, i, 0, 0, 8'h61 + i, 8'h17);
				run(put_char, i, cols - 1, 0, 8'h71 + i, 8'h17);
			end
			fill_row(r);
			run(erase_display, r, $urandom % cols, m % 2, 0, 0);
		end

		test_name = "back_pressure";
		for (int i = 0; i < rows; i++)
			run(put_char, i, 0, 0, 8'h30 + i, 8'h07);
		stalls = 0;
		send(insert_lines, 0, 0, 1, 0, 0);  // seven rows to copy
		send(put_char, 0, 4, 0, 8'h2a, 8'h0e);
		send(delete_chars, 1, 0, 2, 0, 0);
		send(erase_display, 6, 3, 0, 0, 0);
		send(delete_lines, 2, 0, 3, 0, 0);
		send(put_char, 7, 15, 0, 8'h21, 8'h70);
		wait_idle();
		check_screen();
		assert (stalls > 0)
		else
			fail_run("cmd_ready never dropped while the scroll was running");

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/term_text_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module term_text_asserts (
	input logic                clk,
	input logic                rst,
	input logic                cmd_valid,
	input logic                cmd_ready,
	input term_pkg::term_cmd_t cmd,
	input logic                idle,
	input logic                ram_we
);

	// a stalled command keeps its contents until it is taken
	cmd_held: assert property (@(posedge clk) disable iff (rst)
		cmd_valid && !cmd_ready |=> $stable(cmd))
		else $error("command changed while cmd_ready was low");

	no_idle_write: assert property (@(posedge clk) disable iff (rst)
		idle |=> !ram_we)  // a new job waits a cycle in decode before any write
		else $error("RAM write right after the design reported idle");

	ready_in_reset: assert property (@(posedge clk)
		rst |-> !cmd_ready)
		else $error("cmd_ready high during reset");

endmodule

bind term_text_top term_text_asserts asserts_i (
	.clk       (clk),
	.rst       (rst),
	.cmd_valid (cmd_valid),
	.cmd_ready (cmd_ready),
	.cmd       (cmd),
	.idle      (idle),
	.ram_we    (ram_we)
);

`default_nettype wire

/* hw/term_text_top.sv */
`timescale 1ns/1ns
`default_nettype none

module term_text_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                cmd_valid,
	output logic                cmd_ready,
	input  term_pkg::term_cmd_t cmd,
	input  term_pkg::row_t      disp_addr,
	output term_pkg::line_t     disp_line,
	output logic                idle
);
	import term_pkg::*;

	logic      job_valid;
	logic      job_ready;
	edit_job_t job;
	row_t      ram_addr;
	logic      ram_we;
	line_t     ram_wdata;
	line_t     ram_rdata;
	logic      pending;
	logic      busy;

	assign idle = !pending && !busy;  // nothing held and nothing running

	cmd_decode decode_i (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd       (cmd),
		.job_valid (job_valid),
		.job_ready (job_ready),
		.job       (job),
		.pending   (pending)
	);

	text_sequencer seq_i (
		.clk       (clk),
		.rst       (rst),
		.job_valid (job_valid),
		.job_ready (job_ready),
		.job       (job),
		.ram_addr  (ram_addr),
		.ram_we    (ram_we),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata),
		.busy      (busy)
	);

	text_ram ram_i (
		.clk       (clk),
		.addr      (ram_addr),
		.we        (ram_we),
		.wdata     (ram_wdata),
		.rdata     (ram_rdata),
		.disp_addr (disp_addr),
		.disp_line (disp_line)
	);

endmodule

`default_nettype wire

/* hw/text_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module text_ram (
	input  logic            clk,
	input  term_pkg::row_t  addr,
	input  logic            we,
	input  term_pkg::line_t wdata,
	output term_pkg::line_t rdata,
	input  term_pkg::row_t  disp_addr,
	output term_pkg::line_t disp_line
);
	import term_pkg::*;

	line_t mem [rows];

	// edit port reads the old contents when it writes the same row
	always_ff @(posedge clk)
	begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

	always_ff @(posedge clk)
	begin
		disp_line <= mem[disp_addr];  // scanner port, read only
	end

endmodule

`default_nettype wire

/* hw/text_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module text_sequencer (
	input  logic                clk,
	input  logic                rst,
	input  logic                job_valid,
	output logic                job_ready,
	input  term_pkg::edit_job_t job,
	output term_pkg::row_t      ram_addr,
	output logic                ram_we,
	output term_pkg::line_t     ram_wdata,
	input  term_pkg::line_t     ram_rdata,
	output logic                busy
);
	import term_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_edit_rd,   // address the line
		st_edit_cap,  // capture the old line
		st_edit_wr,
		st_copy_rd,
		st_copy_wr,
		st_clear
	} state_t;

	state_t     state;
	edit_job_t  job_q;
	row_t       row_q;     // copy destination or row being cleared
	row_t       row_end;   // last row of the clear span
	line_t      line_q;
	line_t      new_line;
	line_t      blank_line;
	row_t       copy_src;
	row_t       copy_last;
	row_t       clr_lo;
	row_t       clr_hi;
	logic [3:0] survive;   // rows that move in a scroll

	assign blank_line = {cols{blank_cell}};
	assign survive = 4'(rows) - {1'b0, job.row_lo} - job.step;

	// a downward scroll copies bottom up, an upward one top down
	always_comb
	begin
		if (job_q.scroll_down)
		begin
			copy_src = row_t'({1'b0, row_q} - job_q.step);
			copy_last = row_t'({1'b0, job_q.row_lo} + job_q.step);
			clr_lo = job_q.row_lo;
			clr_hi = row_t'({1'b0, job_q.row_lo} + job_q.step - 4'd1);
		end
		else
		begin
			copy_src = row_t'({1'b0, row_q} + job_q.step);
			copy_last = row_t'(4'(rows - 1) - job_q.step);
			clr_lo = row_t'(4'(rows) - job_q.step);
			clr_hi = row_t'(rows - 1);
		end
	end

	line_rewrite rewrite_i (
		.old_line    (line_q),
		.col_lo      (job_q.col_lo),
		.col_hi      (job_q.col_hi),
		.shift       (job_q.shift),
		.shift_right (job_q.shift_right),
		.fill        (job_q.fill),
		.new_line    (new_line)
	);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			state <= st_idle;
		else
		begin
			case (state)
				st_idle:
					if (job_valid)
					begin
						case (job.kind)
							line_edit:
								state <= st_edit_rd;
							line_scroll:
								state <= (survive == 4'd0) ? st_clear : st_copy_rd;
							default:
								state <= st_clear;
						endcase
					end
				st_edit_rd:
					state <= st_edit_cap;
				st_edit_cap:
					state <= st_edit_wr;
				st_edit_wr:
					state <= st_idle;
				st_copy_rd:
					state <= st_copy_wr;
				st_copy_wr:
					state <= (row_q == copy_last) ? st_clear : st_copy_rd;
				st_clear:
					state <= (row_q == row_end) ? st_idle : st_clear;
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		case (state)
			st_idle:
				if (job_valid)
				begin
					job_q <= job;
					row_q <= job.row_lo;
					row_end <= job.row_hi;
					if (job.kind == line_scroll && job.scroll_down && survive != 4'd0)
						row_q <= row_t'(rows - 1);
				end
			st_edit_cap:
				line_q <= ram_rdata;
			st_copy_wr:
				if (row_q == copy_last)
				begin
					row_q <= clr_lo;  // on to the vacated rows
					row_end <= clr_hi;
				end
				else if (job_q.scroll_down)
					row_q <= row_q - 3'd1;
				else
					row_q <= row_q + 3'd1;
			st_clear:
				row_q <= row_q + 3'd1;
			default:
				;
		endcase
	end

	assign job_ready = (state == st_idle);
	assign busy = (state != st_idle);
	assign ram_we = (state == st_edit_wr) || (state == st_copy_wr) || (state == st_clear);

	always_comb
	begin
		case (state)
			st_copy_rd:
				ram_addr = copy_src;
			st_copy_wr, st_clear:
				ram_addr = row_q;
			default:
				ram_addr = job_q.row;
		endcase

		case (state)
			st_copy_wr:
				ram_wdata = ram_rdata;  // source row read in the previous cycle
			st_clear:
				ram_wdata = blank_line;
			default:
				ram_wdata = new_line;
		endcase
	end

endmodule

`default_nettype wire

/* hw/line_rewrite.sv */
`timescale 1ns/1ns
`default_nettype none

module line_rewrite (
	input  term_pkg::line_t old_line,
	input  term_pkg::col_t  col_lo,
	input  term_pkg::col_t  col_hi,
	input  logic [4:0]      shift,
	input  logic            shift_right,
	input  term_pkg::cell_t fill,
	output term_pkg::line_t new_line
);
	import term_pkg::*;

	// each column picks its source cell, then range checks decide keep, move or fill
	always_comb
	begin
		int src;
		int lo;
		int hi;

		lo = int'(col_lo);
		hi = int'(col_hi);
		for (int i = 0; i < cols; i++)
		begin
			if (shift_right)
				src = i - int'(shift);
			else
				src = i + int'(shift);

			if (i < lo || i > hi)
				new_line[i] = old_line[i];  // outside the edited span
			else if (shift == 5'd0)
				new_line[i] = fill;  // plain erase or put
			else if (src < lo || src > hi)
				new_line[i] = fill;  // vacated by the shift
			else
				new_line[i] = old_line[src[3:0]];
		end
	end

endmodule

`default_nettype wire

/* hw/cmd_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module cmd_decode (
	input  logic                clk,
	input  logic                rst,
	input  logic                cmd_valid,
	output logic                cmd_ready,
	input  term_pkg::term_cmd_t cmd,
	output logic                job_valid,
	input  logic                job_ready,
	output term_pkg::edit_job_t job,
	output logic                pending
);
	import term_pkg::*;

	edit_job_t  base;
	edit_job_t  first_job;
	edit_job_t  second_job;
	edit_job_t  next_job;    // second half of a split erase_display
	logic       has_second;
	logic       next_valid;
	logic       drop;
	logic       active;      // high from the first edge after reset
	logic       accept;
	logic [7:0] cnt;
	logic [7:0] ch_fix;
	logic [8:0] end_col;
	logic [3:0] avail;       // rows from the cursor row down

	assign accept = cmd_valid && cmd_ready;
	assign cmd_ready = active && (!job_valid || (job_ready && !next_valid));
	assign pending = job_valid;

	always_comb
	begin
		cnt = (cmd.count == 8'd0) ? 8'd1 : cmd.count;
		ch_fix = (cmd.ch == 8'd0) ? 8'h20 : cmd.ch;
		end_col = {5'd0, cmd.col} + {1'b0, cnt} - 9'd1;
		avail = 4'(rows) - {1'b0, cmd.row};

		base = '0;
		base.kind = line_edit;
		base.row = cmd.row;
		base.col_lo = cmd.col;
		base.col_hi = col_t'(cols - 1);
		base.fill = blank_cell;
		base.row_lo = cmd.row;
		base.row_hi = row_t'(rows - 1);

		first_job = base;
		second_job = base;
		has_second = 1'b0;
		drop = 1'b0;

		// the partial line shared by erase_line and erase_display
		second_job.col_lo = (cmd.count != 8'd0) ? 4'd0 : cmd.col;
		second_job.col_hi = (cmd.count != 8'd1) ? col_t'(cols - 1) : cmd.col;

		case (cmd.op)
			put_char:
			begin
				drop = ch_fix < 8'h20;  // control codes leave the screen alone
				first_job.col_hi = cmd.col;
				first_job.fill = '{attr: cmd.attr, ch: ch_fix};
			end
			erase_line:
				first_job = second_job;
			erase_chars:
				first_job.col_hi = (end_col > 9'(cols - 1)) ? col_t'(cols - 1) : end_col[3:0];
			insert_chars, delete_chars:
			begin
				first_job.shift = (cnt >= 8'(cols)) ? 5'(cols) : cnt[4:0];
				first_job.shift_right = (cmd.op == insert_chars);
			end
			insert_lines, delete_lines:
			begin
				first_job.kind = line_scroll;
				first_job.scroll_down = (cmd.op == insert_lines);
				first_job.step = (cnt > {4'd0, avail}) ? avail : cnt[3:0];
			end
			erase_display:
			begin
				first_job.kind = row_clear;
				if (cmd.count >= 8'd2)
					first_job.row_lo = 3'd0;
				else if (cmd.count == 8'd0)
				begin
					first_job.row_lo = cmd.row + 3'd1;
					has_second = (cmd.row != row_t'(rows - 1));
				end
				else
				begin
					first_job.row_lo = 3'd0;
					first_job.row_hi = cmd.row - 3'd1;
					has_second = (cmd.row != 3'd0);
				end
				// cursor on the edge row leaves only the partial line
				if (cmd.count < 8'd2 && !has_second)
					first_job = second_job;
			end
			default:
				drop = 1'b1;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			active <= 1'b0;
			job_valid <= 1'b0;
			next_valid <= 1'b0;
		end
		else
		begin
			active <= 1'b1;
			if (job_valid && job_ready)
			begin
				job_valid <= next_valid;  // stays up when a second part follows
				next_valid <= 1'b0;
			end
			if (accept && !drop)
			begin
				job_valid <= 1'b1;
				next_valid <= has_second;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (job_valid && job_ready && next_valid)
			job <= next_job;
		if (accept && !drop)
		begin
			job <= first_job;
			next_job <= second_job;
		end
	end

endmodule

`default_nettype wire

/* hw/term_pkg.sv */
`default_nettype none

package term_pkg;

	localparam int cols = 16;
	localparam int rows = 8;

	typedef logic [3:0] col_t;
	typedef logic [2:0] row_t;

	localparam logic [7:0] blank_attr = 8'h07;

	typedef struct packed {
		logic [7:0] attr;
		logic [7:0] ch;
	} cell_t;

	localparam cell_t blank_cell = '{attr: blank_attr, ch: 8'h20};  // what erased cells hold

	typedef cell_t [cols-1:0] line_t;  // cell 0 is the leftmost column

	typedef enum logic [2:0] {
		put_char,
		erase_line,
		erase_chars,
		insert_chars,
		delete_chars,
		insert_lines,
		delete_lines,
		erase_display
	} cmd_op_t;

	typedef struct packed {
		cmd_op_t    op;
		row_t       row;
		col_t       col;
		logic [7:0] count;  // repeat count or erase mode
		logic [7:0] ch;
		logic [7:0] attr;
	} term_cmd_t;

	typedef enum logic [1:0] {
		line_edit,
		line_scroll,
		row_clear
	} job_kind_t;

	typedef struct packed {
		job_kind_t  kind;
		row_t       row;
		col_t       col_lo;       // inclusive
		col_t       col_hi;
		logic [4:0] shift;        // 0 .. cols
		logic       shift_right;
		cell_t      fill;
		row_t       row_lo;       // rows touched by clears and scrolls
		row_t       row_hi;
		logic       scroll_down;
		logic [3:0] step;         // rows to scroll
	} edit_job_t;

endpackage

`default_nettype wire
